// ==== hw/bus_params.svh ====
/* Main-bus constants for the 68000-side glue.
   Addresses are byte-address pages; the bus itself carries word addresses. */
`ifndef BUS_PARAMS_SVH
`define BUS_PARAMS_SVH

// Widths
`define BUS_ADDR_W 23
`define WRAM_ADDR_W 15
`define ZRAM_ADDR_W 13

// CPU clock-enable periods in MCLK cycles, per turbo setting
`define TURBO_DIV_0 7
`define TURBO_DIV_1 4
`define TURBO_DIV_2 2

// Memory map
`define ZBUS_PAGE 8'hA0
`define CTRL_BUSREQ_PAGE 16'hA111
`define CTRL_RESET_PAGE 16'hA112
`define WRAM_TOP_BITS 3'b111

// Open bus after reset holds a NOP opcode
`define OPEN_BUS_RESET 16'h4E71

`endif

// ==== hw/bus_pkg.sv ====
/* Shared bus types; widths come from bus_params.svh */
`default_nettype none
`include "bus_params.svh"

package bus_pkg;

	typedef logic [15:0] word_t;
	typedef logic [7:0] byte_t;
	typedef logic [`BUS_ADDR_W-1:0] bus_addr_t;

	typedef enum logic [2:0] {
		MS_IDLE,
		MS_SELECT,
		MS_WRAM_READ,
		MS_ROM_READ,
		MS_ZBUS_WAIT,
		MS_ZBUS_WRITE_WAIT,
		MS_ZBUS_READ,
		MS_FINISH
	} mbus_state_t;

	typedef enum logic [1:0] {
		ZS_IDLE,
		ZS_READ,
		ZS_FINISH
	} zbus_state_t;

	// Decoded target of a main-bus cycle
	typedef enum logic [2:0] {
		RG_ROM,
		RG_ZERO,
		RG_ZBUS,
		RG_CTRL,
		RG_WRAM,
		RG_OPEN
	} region_t;

endpackage

`default_nettype wire

// ==== hw/cpu_clock_enables.sv ====
/* CPU phase enables derived from MCLK; turbo 3 behaves as turbo 2.
   A new turbo value is picked up only when the current period wraps. */
`timescale 1ns/1ps
`default_nettype none
`include "bus_params.svh"

module cpu_clock_enables (
	input wire logic MCLK,
	input wire logic reset,
	input wire logic [1:0] turbo,
	output logic ce_p,
	output logic ce_n
);

	logic [2:0] cnt;
	logic [2:0] cnt_max;
	logic [2:0] cnt_mid;
	logic [2:0] next_max;

	// Terminal count for the requested divide
	always_comb begin
		case (turbo)
			2'd0: next_max = 3'(`TURBO_DIV_0 - 1);
			2'd1: next_max = 3'(`TURBO_DIV_1 - 1);
			default: next_max = 3'(`TURBO_DIV_2 - 1);
		endcase
	end

	always_ff @(posedge MCLK) begin
		if (reset) begin
			cnt <= '0;
			cnt_max <= 3'(`TURBO_DIV_0 - 1);
			cnt_mid <= 3'((`TURBO_DIV_0 - 1) / 2);
			ce_p <= 1'b0;
			ce_n <= 1'b0;
		end else begin
			ce_p <= 1'b0;
			cnt <= cnt + 3'd1;
			// Wrap: phase 1 and latch the next period
			if (cnt == cnt_max) begin
				cnt <= '0;
				ce_p <= 1'b1;
				cnt_max <= next_max;
				cnt_mid <= next_max >> 1;
			end
			// Phase 2 halfway through
			ce_n <= (cnt == cnt_mid);
		end
	end

endmodule

`default_nettype wire

// ==== hw/sync_ram.sv ====
/* Single-port byte RAM, one-cycle registered read.
   A write returns the new byte on the same edge. */
`timescale 1ns/1ps
`default_nettype none

module sync_ram import bus_pkg::*; #(
	parameter int ADDR_W = 13
) (
	input wire logic MCLK,
	input wire logic [ADDR_W-1:0] addr,
	input wire byte_t wdata,
	input wire logic we,
	output byte_t rdata
);

	byte_t mem [0:(1 << ADDR_W) - 1];

	always_ff @(posedge MCLK) begin
		if (we) begin
			mem[addr] <= wdata;
			rdata <= wdata;
		end else begin
			rdata <= mem[addr];
		end
	end

endmodule

`default_nettype wire

// ==== hw/z80_bus_arbiter.sv ====
/* Z80-side bus seen from the 68000 only; no Z80 master is arbitrated.
   Bus grant follows the request at once, so busreq state doubles as busack. */
`timescale 1ns/1ps
`default_nettype none
`include "bus_params.svh"

module z80_bus_arbiter import bus_pkg::*; (
	input wire logic MCLK,
	input wire logic reset,
	input wire logic zbus_sel,
	input wire bus_addr_t bus_addr,
	input wire logic uds_n,
	input wire logic rnw,
	input wire word_t wdata,
	output byte_t zbus_data,
	output logic zbus_dtack_n,
	input wire logic ctrl_wr,
	input wire logic [15:0] ctrl_page,
	input wire logic ctrl_data,
	output logic ctrl_bit,
	output logic z80_busreq_n,
	output logic z80_reset_n
);

	zbus_state_t zstate;
	logic [14:0] zaddr;
	byte_t zdin;
	logic zwe;
	byte_t zram_q;
	logic bus_free;
	logic zram_sel;

	// 68000 may touch Z80 space only with the bus held and the Z80 running
	assign bus_free = ~z80_busreq_n & z80_reset_n;

	// 8 KB RAM at 0000, mirrored up to 3FFF
	assign zram_sel = ~zaddr[14];

	assign ctrl_bit = (ctrl_page == `CTRL_BUSREQ_PAGE) ? z80_busreq_n : z80_reset_n;

	sync_ram #(
		.ADDR_W(`ZRAM_ADDR_W)
	) u_zram (
		.MCLK(MCLK),
		.addr(zaddr[`ZRAM_ADDR_W-1:0]),
		.wdata(zdin),
		.we(zwe & zram_sel),
		.rdata(zram_q)
	);

	// ------------------------------
	// Transfer FSM
	// ------------------------------
	always_ff @(posedge MCLK) begin
		zwe <= 1'b0;
		if (reset) begin
			zstate <= ZS_IDLE;
			zbus_dtack_n <= 1'b1;
		end else begin
			if (!zbus_sel) zbus_dtack_n <= 1'b1;

			case (zstate)
				ZS_IDLE: begin
					if (zbus_sel && zbus_dtack_n) begin
						// Upper lane is the even byte
						zaddr <= {bus_addr[13:0], uds_n};
						zdin <= !uds_n ? wdata[15:8] : wdata[7:0];
						zwe <= ~rnw & bus_free;
						zstate <= ZS_READ;
					end
				end
				ZS_READ: zstate <= ZS_FINISH;
				ZS_FINISH: begin
					zbus_data <= (bus_free && zram_sel) ? zram_q : 8'hFF;
					zbus_dtack_n <= 1'b0;
					zstate <= ZS_IDLE;
				end
				default: zstate <= ZS_IDLE;
			endcase
		end
	end

	// ------------------------------
	// Control registers
	// ------------------------------
	always_ff @(posedge MCLK) begin
		if (reset) begin
			z80_busreq_n <= 1'b1;
			z80_reset_n <= 1'b0;
		end else if (ctrl_wr) begin
			if (ctrl_page == `CTRL_BUSREQ_PAGE) z80_busreq_n <= ~ctrl_data;
			if (ctrl_page == `CTRL_RESET_PAGE) z80_reset_n <= ctrl_data;
		end
	end

endmodule

`default_nettype wire

// ==== hw/main_bus_controller.sv ====
/* Main-bus glue for a single 68000-style master; ROM writes are dropped.
   Unmapped reads return the last ROM or work-RAM word the CPU read. */
`timescale 1ns/1ps
`default_nettype none
`include "bus_params.svh"

module main_bus_controller import bus_pkg::*; (
	input wire logic MCLK,
	input wire logic reset,
	input wire logic ce_p,
	input wire logic as_n,
	input wire logic rnw,
	input wire logic uds_n,
	input wire logic lds_n,
	input wire bus_addr_t addr,
	input wire word_t wdata,
	output word_t rdata,
	output logic dtack_n,
	input wire bus_addr_t rom_size,
	output bus_addr_t rom_addr,
	output logic rom_req,
	input wire logic rom_ack,
	input wire word_t rom_data,
	output logic zbus_sel,
	output bus_addr_t bus_addr,
	output logic bus_uds_n,
	output logic bus_rnw,
	output word_t bus_wdata,
	input wire byte_t zbus_data,
	input wire logic zbus_dtack_n,
	output logic ctrl_wr,
	output logic [15:0] ctrl_page,
	output logic ctrl_data,
	input wire logic ctrl_bit
);

	mbus_state_t state;
	region_t region;
	bus_addr_t mbus_addr;
	logic mbus_rnw;
	word_t mbus_wdata;
	word_t data;
	word_t open_bus;
	logic wram_sel;
	byte_t wram_q_hi;
	byte_t wram_q_lo;

	assign rom_addr = mbus_addr;
	assign bus_addr = mbus_addr;
	assign bus_rnw = mbus_rnw;
	assign bus_wdata = mbus_wdata;
	assign ctrl_page = mbus_addr[22:7];
	assign ctrl_data = mbus_wdata[8];

	// ------------------------------
	// Address decode
	// ------------------------------
	always_comb begin
		if (mbus_addr < rom_size) begin
			region = RG_ROM;
		end else if (mbus_addr[22:19] < 4'hA) begin
			region = RG_ZERO;
		end else if (mbus_addr[22:15] == `ZBUS_PAGE) begin
			region = RG_ZBUS;
		end else if ((mbus_addr[22:7] == `CTRL_BUSREQ_PAGE ||
				mbus_addr[22:7] == `CTRL_RESET_PAGE) && mbus_addr[6:0] == 7'd0) begin
			region = RG_CTRL;
		end else if (mbus_addr[22:20] == `WRAM_TOP_BITS) begin
			region = RG_WRAM;
		end else begin
			region = RG_OPEN;
		end
	end

	// Work RAM, 64 KB as two byte lanes, mirrored over E00000-FFFFFF
	sync_ram #(
		.ADDR_W(`WRAM_ADDR_W)
	) u_wram_hi (
		.MCLK(MCLK),
		.addr(mbus_addr[`WRAM_ADDR_W-1:0]),
		.wdata(mbus_wdata[15:8]),
		.we(wram_sel & ~mbus_rnw & ~uds_n),
		.rdata(wram_q_hi)
	);

	sync_ram #(
		.ADDR_W(`WRAM_ADDR_W)
	) u_wram_lo (
		.MCLK(MCLK),
		.addr(mbus_addr[`WRAM_ADDR_W-1:0]),
		.wdata(mbus_wdata[7:0]),
		.we(wram_sel & ~mbus_rnw & ~lds_n),
		.rdata(wram_q_lo)
	);

	// ------------------------------
	// Transfer FSM
	// ------------------------------
	always_ff @(posedge MCLK) begin
		if (reset) begin
			state <= MS_IDLE;
			dtack_n <= 1'b1;
			zbus_sel <= 1'b0;
			wram_sel <= 1'b0;
			ctrl_wr <= 1'b0;
			rom_req <= rom_ack;
			open_bus <= `OPEN_BUS_RESET;
		end else begin
			ctrl_wr <= 1'b0;
			if (as_n) dtack_n <= 1'b1;

			case (state)
				MS_IDLE: begin
					wram_sel <= 1'b0;
					if (!as_n && dtack_n) begin
						mbus_addr <= addr;
						mbus_rnw <= rnw;
						mbus_wdata <= wdata;
						data <= open_bus;
						state <= MS_SELECT;
					end
				end
				MS_SELECT: begin
					state <= MS_FINISH;
					case (region)
						RG_ROM: begin
							if (mbus_rnw) begin
								rom_req <= ~rom_ack;
								state <= MS_ROM_READ;
							end
						end
						RG_ZERO: data <= '0;
						RG_ZBUS: state <= MS_ZBUS_WAIT;
						RG_CTRL: data <= {open_bus[15:9], ctrl_bit, open_bus[7:0]};
						RG_WRAM: begin
							wram_sel <= 1'b1;
							state <= MS_WRAM_READ;
						end
						default: data <= open_bus;
					endcase
				end
				MS_WRAM_READ: begin
					data <= {wram_q_hi, wram_q_lo};
					if (mbus_rnw) open_bus <= {wram_q_hi, wram_q_lo};
					state <= MS_FINISH;
				end
				MS_ROM_READ: begin
					if (rom_req == rom_ack) begin
						data <= rom_data;
						open_bus <= rom_data;
						state <= MS_FINISH;
					end
				end
				// Byte lane is known only once the strobes are out
				MS_ZBUS_WAIT: begin
					if (as_n || !uds_n || !lds_n) begin
						bus_uds_n <= uds_n;
						if (mbus_rnw) begin
							zbus_sel <= 1'b1;
							state <= MS_ZBUS_READ;
						end else begin
							state <= MS_ZBUS_WRITE_WAIT;
						end
					end
				end
				MS_ZBUS_WRITE_WAIT: begin
					if (ce_p) begin
						zbus_sel <= 1'b1;
						state <= MS_ZBUS_READ;
					end
				end
				MS_ZBUS_READ: begin
					if (!zbus_dtack_n) begin
						zbus_sel <= 1'b0;
						data <= {zbus_data, zbus_data};
						state <= MS_FINISH;
					end
				end
				MS_FINISH: begin
					rdata <= data;
					dtack_n <= 1'b0;
					if (as_n || mbus_rnw || !uds_n || !lds_n) begin
						// Control bits sit in the upper byte
						if (region == RG_CTRL && !mbus_rnw && !uds_n) ctrl_wr <= 1'b1;
						state <= MS_IDLE;
					end
				end
				default: state <= MS_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== hw/console_bus_top.sv ====
/* Main-bus side of the console glue; CPUs and the ROM live outside.
   The phase-2 enable is generated but not brought out. */
`timescale 1ns/1ps
`default_nettype none

module console_bus_top import bus_pkg::*; (
	input wire logic MCLK,
	input wire logic reset,
	input wire logic [1:0] turbo,
	input wire logic as_n,
	input wire logic rnw,
	input wire logic uds_n,
	input wire logic lds_n,
	input wire bus_addr_t addr,
	input wire word_t wdata,
	output word_t rdata,
	output logic dtack_n,
	input wire bus_addr_t rom_size,
	output bus_addr_t rom_addr,
	output logic rom_req,
	input wire logic rom_ack,
	input wire word_t rom_data,
	output logic ce_p,
	output logic z80_busreq_n,
	output logic z80_reset_n
);

	// Controller to arbiter link
	logic zbus_sel;
	bus_addr_t bus_addr;
	logic bus_uds_n;
	logic bus_rnw;
	word_t bus_wdata;
	byte_t zbus_data;
	logic zbus_dtack_n;
	logic ctrl_wr;
	logic [15:0] ctrl_page;
	logic ctrl_data;
	logic ctrl_bit;

	cpu_clock_enables u_clk_en (
		.MCLK(MCLK),
		.reset(reset),
		.turbo(turbo),
		.ce_p(ce_p),
		.ce_n()
	);

	main_bus_controller u_mbus (
		.MCLK(MCLK),
		.reset(reset),
		.ce_p(ce_p),
		.as_n(as_n),
		.rnw(rnw),
		.uds_n(uds_n),
		.lds_n(lds_n),
		.addr(addr),
		.wdata(wdata),
		.rdata(rdata),
		.dtack_n(dtack_n),
		.rom_size(rom_size),
		.rom_addr(rom_addr),
		.rom_req(rom_req),
		.rom_ack(rom_ack),
		.rom_data(rom_data),
		.zbus_sel(zbus_sel),
		.bus_addr(bus_addr),
		.bus_uds_n(bus_uds_n),
		.bus_rnw(bus_rnw),
		.bus_wdata(bus_wdata),
		.zbus_data(zbus_data),
		.zbus_dtack_n(zbus_dtack_n),
		.ctrl_wr(ctrl_wr),
		.ctrl_page(ctrl_page),
		.ctrl_data(ctrl_data),
		.ctrl_bit(ctrl_bit)
	);

	z80_bus_arbiter u_zbus (
		.MCLK(MCLK),
		.reset(reset),
		.zbus_sel(zbus_sel),
		.bus_addr(bus_addr),
		.uds_n(bus_uds_n),
		.rnw(bus_rnw),
		.wdata(bus_wdata),
		.zbus_data(zbus_data),
		.zbus_dtack_n(zbus_dtack_n),
		.ctrl_wr(ctrl_wr),
		.ctrl_page(ctrl_page),
		.ctrl_data(ctrl_data),
		.ctrl_bit(ctrl_bit),
		.z80_busreq_n(z80_busreq_n),
		.z80_reset_n(z80_reset_n)
	);

endmodule

`default_nettype wire

// ==== verification/rom_model.sv ====
/* Cartridge ROM stand-in; each word holds the low 16 bits of its word address.
   The answer comes a few cycles after a request toggle. */
`timescale 1ns/1ps
`default_nettype none

module rom_model import bus_pkg::*; (
	input wire logic MCLK,
	input wire logic reset,
	input wire bus_addr_t rom_addr,
	input wire logic rom_req,
	output logic rom_ack,
	output word_t rom_data
);

	logic [1:0] wait_cnt;

	always_ff @(posedge MCLK) begin
		if (reset) begin
			rom_ack <= 1'b0;
			wait_cnt <= '0;
		end else if (rom_req != rom_ack) begin
			wait_cnt <= wait_cnt + 2'd1;
			// Data and acknowledge move together
			if (wait_cnt == 2'd2) begin
				rom_data <= rom_addr[15:0];
				rom_ack <= rom_req;
				wait_cnt <= '0;
			end
		end
	end

endmodule

`default_nettype wire

// ==== verification/tb_console_bus.sv ====
/* Directed tests of the console bus glue; test addresses are byte addresses.
   ROM size is fixed at 1 MB, turbo stays 0 outside the divide test. */
`timescale 1ns/1ps
`default_nettype none

module tb_console_bus import bus_pkg::*; ();

	// About 50 bus cycles of under 30 clocks plus the turbo sweep, with wide margin
	localparam int TIMEOUT_CYCLES = 20000;
	localparam logic [23:0] UNMAPPED = 24'hC00000;
	localparam logic [23:0] ZWIN = 24'hA00100;
	localparam logic [23:0] BUSREQ = 24'hA11100;
	localparam logic [23:0] Z80RESET = 24'hA11200;

	logic MCLK = 1'b0;
	logic reset;
	logic [1:0] turbo;
	logic as_n;
	logic rnw;
	logic uds_n;
	logic lds_n;
	bus_addr_t addr;
	word_t wdata;
	word_t rdata;
	logic dtack_n;
	bus_addr_t rom_size;
	bus_addr_t rom_addr;
	logic rom_req;
	logic rom_ack;
	word_t rom_data;
	logic ce_p;
	logic z80_busreq_n;
	logic z80_reset_n;

	integer seed = 32'h2c76_b2d5;
	int errors = 0;
	int checks = 0;
	int tests_run = 0;
	int cycle_count = 0;
	int last_latency;
	// Expected open-bus word
	word_t ob_model;

	console_bus_top uut (
		.MCLK(MCLK),
		.reset(reset),
		.turbo(turbo),
		.as_n(as_n),
		.rnw(rnw),
		.uds_n(uds_n),
		.lds_n(lds_n),
		.addr(addr),
		.wdata(wdata),
		.rdata(rdata),
		.dtack_n(dtack_n),
		.rom_size(rom_size),
		.rom_addr(rom_addr),
		.rom_req(rom_req),
		.rom_ack(rom_ack),
		.rom_data(rom_data),
		.ce_p(ce_p),
		.z80_busreq_n(z80_busreq_n),
		.z80_reset_n(z80_reset_n)
	);

	rom_model u_rom (
		.MCLK(MCLK),
		.reset(reset),
		.rom_addr(rom_addr),
		.rom_req(rom_req),
		.rom_ack(rom_ack),
		.rom_data(rom_data)
	);

	always #50 MCLK = ~MCLK;

	always @(posedge MCLK) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout after %0d cycles, a test stopped making progress", TIMEOUT_CYCLES);
			$display("FAIL: see errors above");
			$finish;
		end
	end

	// ------------------------------
	// Bus helpers
	// ------------------------------
	task automatic bus_cycle(input logic [23:0] byte_addr, input logic read,
			input logic [1:0] strobe_n, input word_t wr, output word_t rd);
		int cycles;
		cycles = 0;
		@(posedge MCLK);
		addr <= byte_addr[23:1];
		rnw <= read;
		wdata <= wr;
		uds_n <= strobe_n[1];
		lds_n <= strobe_n[0];
		as_n <= 1'b0;
		@(negedge MCLK);
		while (dtack_n !== 1'b0) begin
			@(negedge MCLK);
			cycles++;
		end
		rd = rdata;
		last_latency = cycles;
		// End the cycle and wait for DTACK to let go
		@(posedge MCLK);
		as_n <= 1'b1;
		uds_n <= 1'b1;
		lds_n <= 1'b1;
		rnw <= 1'b1;
		@(negedge MCLK);
		while (dtack_n !== 1'b1) @(negedge MCLK);
	endtask

	task automatic cpu_read(input logic [23:0] byte_addr, input logic [1:0] strobe_n,
			output word_t rd);
		bus_cycle(byte_addr, 1'b1, strobe_n, 16'h0000, rd);
	endtask

	task automatic cpu_write(input logic [23:0] byte_addr, input logic [1:0] strobe_n,
			input word_t wr);
		word_t unused_rd;
		bus_cycle(byte_addr, 1'b0, strobe_n, wr, unused_rd);
	endtask

	// Counts clocks from one ce_p pulse to the next
	task automatic measure_ce_period(output int period);
		period = 0;
		@(negedge MCLK);
		while (ce_p !== 1'b1) @(negedge MCLK);
		@(negedge MCLK);
		period = 1;
		while (ce_p !== 1'b1) begin
			@(negedge MCLK);
			period++;
		end
	endtask

	// ROM word at a byte address is its word address
	function automatic word_t rom_word(input logic [23:0] byte_addr);
		return byte_addr[16:1];
	endfunction

	// ------------------------------
	// Checks and reporting
	// ------------------------------
	task automatic expect_word(input string name, input word_t got, input word_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERROR at %0t ns: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic expect_bit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERROR at %0t ns: %s is %b, expected %b", $time, name, got, exp);
		end
	endtask

	task automatic expect_int(input string name, input int got, input int exp);
		checks++;
		if (got != exp) begin
			errors++;
			$display("ERROR at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic finish_test(input string name, input int err0);
		tests_run++;
		$display("Test %0d %s done, %0d errors", tests_run, name, errors - err0);
	endtask

	// ------------------------------
	// Directed tests
	// ------------------------------
	task automatic test_open_bus_reset();
		int err0;
		word_t rd;
		err0 = errors;
		cpu_read(UNMAPPED, 2'b00, rd);
		expect_word("rdata", rd, 16'h4E71);
		finish_test("open bus reset value", err0);
	endtask

	task automatic test_work_ram();
		int err0;
		word_t rd;
		word_t pattern [4];
		logic [23:0] a;
		err0 = errors;
		for (int i = 0; i < 4; i++) begin
			a = 24'hE00000 + 24'(i) * 24'h002468;
			pattern[i] = 16'($random(seed));
			cpu_write(a, 2'b00, pattern[i]);
		end
		for (int i = 0; i < 4; i++) begin
			a = 24'hE00000 + 24'(i) * 24'h002468;
			cpu_read(a, 2'b00, rd);
			expect_word("rdata", rd, pattern[i]);
			checks++;
			if (last_latency < 4) begin
				errors++;
				$display("Work RAM read at %h took %0d cycles, fewer than 4", a, last_latency);
			end
			// 64 KB mirror
			cpu_read(a + 24'h010000, 2'b00, rd);
			expect_word("rdata", rd, pattern[i]);
		end
		cpu_write(24'hE00000, 2'b10, 16'hAA55);
		cpu_read(24'hE00000, 2'b00, rd);
		expect_word("rdata", rd, {pattern[0][15:8], 8'h55});
		ob_model = {pattern[0][15:8], 8'h55};
		// Last work-RAM word read is now open bus
		cpu_read(UNMAPPED, 2'b00, rd);
		expect_word("rdata", rd, ob_model);
		finish_test("work RAM", err0);
	endtask

	task automatic test_rom_reads();
		int err0;
		word_t rd;
		err0 = errors;
		cpu_read(24'h000246, 2'b00, rd);
		expect_word("rdata", rd, rom_word(24'h000246));
		cpu_read(24'h0ABCDE, 2'b00, rd);
		expect_word("rdata", rd, rom_word(24'h0ABCDE));
		ob_model = rom_word(24'h0ABCDE);
		// First word past the ROM size
		cpu_read(24'h100000, 2'b00, rd);
		expect_word("rdata", rd, 16'h0000);
		cpu_read(UNMAPPED, 2'b00, rd);
		expect_word("rdata", rd, ob_model);
		finish_test("ROM reads", err0);
	endtask

	task automatic test_locked_z80();
		int err0;
		word_t rd;
		err0 = errors;
		cpu_read(ZWIN, 2'b00, rd);
		expect_word("rdata", rd, 16'hFFFF);
		cpu_write(ZWIN, 2'b01, 16'h7700);
		cpu_read(BUSREQ, 2'b00, rd);
		expect_word("rdata", rd, {ob_model[15:9], 1'b1, ob_model[7:0]});
		expect_bit("z80_reset_n", z80_reset_n, 1'b0);
		expect_bit("z80_busreq_n", z80_busreq_n, 1'b1);
		finish_test("locked Z80 window", err0);
	endtask

	task automatic test_z80_ram();
		int err0;
		word_t rd;
		err0 = errors;
		cpu_write(BUSREQ, 2'b00, 16'h0100);
		cpu_write(Z80RESET, 2'b00, 16'h0100);
		expect_bit("z80_busreq_n", z80_busreq_n, 1'b0);
		expect_bit("z80_reset_n", z80_reset_n, 1'b1);
		cpu_read(BUSREQ, 2'b00, rd);
		expect_word("rdata", rd, {ob_model[15:9], 1'b0, ob_model[7:0]});
		// Byte written while locked must not be in the RAM
		cpu_read(ZWIN, 2'b00, rd);
		checks++;
		if (rd === 16'h7777) begin
			errors++;
			$display("Z80 RAM at %h holds the byte written while the bus was locked", ZWIN);
		end
		// Even byte on the upper lane, odd byte on the lower
		cpu_write(ZWIN, 2'b01, 16'h5A00);
		cpu_write(ZWIN + 24'd1, 2'b10, 16'h00C3);
		cpu_read(ZWIN, 2'b00, rd);
		expect_word("rdata", rd, 16'h5A5A);
		cpu_read(ZWIN + 24'd1, 2'b10, rd);
		expect_word("rdata", rd, 16'hC3C3);
		cpu_read(ZWIN + 24'h002000, 2'b00, rd);
		expect_word("rdata", rd, 16'h5A5A);
		// Bus released again, so the write must be dropped
		cpu_write(BUSREQ, 2'b00, 16'h0000);
		cpu_write(ZWIN, 2'b01, 16'hEE00);
		cpu_read(ZWIN, 2'b00, rd);
		expect_word("rdata", rd, 16'hFFFF);
		cpu_write(BUSREQ, 2'b00, 16'h0100);
		cpu_read(ZWIN, 2'b00, rd);
		expect_word("rdata", rd, 16'h5A5A);
		finish_test("Z80 RAM window", err0);
	endtask

	task automatic test_turbo_divide();
		int err0;
		int period;
		int expected [3] = '{7, 4, 2};
		err0 = errors;
		for (int t = 0; t < 3; t++) begin
			@(posedge MCLK);
			turbo <= 2'(t);
			// First period may still run at the old divide
			measure_ce_period(period);
			measure_ce_period(period);
			expect_int("ce_p period", period, expected[t]);
		end
		@(posedge MCLK);
		turbo <= 2'd0;
		finish_test("turbo divide", err0);
	endtask

	initial begin
		reset <= 1'b1;
		turbo <= 2'd0;
		as_n <= 1'b1;
		rnw <= 1'b1;
		uds_n <= 1'b1;
		lds_n <= 1'b1;
		addr <= '0;
		wdata <= '0;
		rom_size <= 23'h080000;
		ob_model = 16'h4E71;
		repeat (10) @(posedge MCLK);
		reset <= 1'b0;

		test_open_bus_reset();
		test_work_ram();
		test_rom_reads();
		test_locked_z80();
		test_z80_ram();
		test_turbo_divide();

		$display("Tests run %0d, checks %0d, errors %0d", tests_run, checks, errors);
		if (errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+hw
hw/bus_pkg.sv
hw/cpu_clock_enables.sv
hw/sync_ram.sv
hw/z80_bus_arbiter.sv
hw/main_bus_controller.sv
hw/console_bus_top.sv
verification/rom_model.sv
verification/tb_console_bus.sv

// ==== Makefile ====
SOURCES := $(wildcard hw/*.sv hw/*.svh verification/*.sv)

.PHONY: run clean

run: obj_dir/Vtb_console_bus
	./obj_dir/Vtb_console_bus | tee sim.log
	grep -q "^PASS: all tests$$" sim.log

obj_dir/Vtb_console_bus: vlog.f $(SOURCES)
	verilator --binary --timing --top-module tb_console_bus -f vlog.f

clean:
	rm -rf obj_dir sim.log
